// File: verilog/uart_pkg.sv
package uart_pkg;

  localparam int n_chan = 4;
  localparam int chan_w = 2;
  typedef logic [chan_w-1:0] chan_t;

  localparam int cmd_w = 16;
  typedef logic [cmd_w-1:0] cmd_t;

  typedef logic [7:0] byte_t;

  // parity-error flag sits above the byte
  typedef logic [8:0] read_t;

  // 1.8432 MHz clock over 115200 baud
  localparam int clks_per_bit = 16;
  typedef logic [4:0] cnt_t;

  // start, eight data, parity, stop
  localparam int frame_bits = 11;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_parity,
    tx_stop
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_t;

  typedef enum logic [1:0] {
    hs_idle,
    hs_wait_ack,
    hs_wait_release,
    hs_done
  } hs_state_t;

endpackage

// File: verilog/baud_tick.sv
module baud_tick (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic half,
  output logic tick
);

  uart_pkg::cnt_t cnt;

  // held at the preload while stopped, so the first period can be short
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= half ? uart_pkg::cnt_t'(uart_pkg::clks_per_bit / 2) : '0;
    end else if (tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign tick = (cnt == uart_pkg::cnt_t'(uart_pkg::clks_per_bit - 1));

  // owner must only stop the counter on a tick
  a_no_idle_tick: assert property (
    @(posedge clk) disable iff (!rst_n)
    !run |-> !tick
  );

endmodule

// File: verilog/uart_tx.sv
module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  uart_pkg::byte_t data,
  output logic            tx,
  output logic            busy,
  output logic            done
);

  uart_pkg::tx_state_t state;
  logic [uart_pkg::frame_bits-1:0] frame;
  logic [2:0] bit_cnt;
  logic tick;

  assign busy = (state != uart_pkg::tx_idle);

  baud_tick u_tick (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (busy),
    .half  (1'b0),
    .tick  (tick)
  );

  // frame[0] is the bit on the line with ones shifting in behind the stop bit
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      frame <= {1'b1, ~^data, data, 1'b0};
    end else if (tick) begin
      frame <= {1'b1, frame[uart_pkg::frame_bits-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::tx_idle;
      bit_cnt <= '0;
      tx      <= 1'b1;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        uart_pkg::tx_idle: begin
          if (start) begin
            state   <= uart_pkg::tx_start;
            bit_cnt <= '0;
            tx      <= 1'b0;
          end
        end
        uart_pkg::tx_start: begin
          if (tick) begin
            state <= uart_pkg::tx_data;
            tx    <= frame[1];
          end
        end
        uart_pkg::tx_data: begin
          if (tick) begin
            tx      <= frame[1];
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::tx_parity;
            end
          end
        end
        uart_pkg::tx_parity: begin
          if (tick) begin
            state <= uart_pkg::tx_stop;
            tx    <= frame[1];
          end
        end
        uart_pkg::tx_stop: begin
          if (tick) begin
            state <= uart_pkg::tx_idle;
            done  <= 1'b1;
          end
        end
        default: state <= uart_pkg::tx_idle;
      endcase
    end
  end

  // channel sequencer must wait for done
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(start && busy)
  );

endmodule

// File: verilog/uart_rx.sv
module uart_rx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx,
  output logic            valid,
  output uart_pkg::read_t word
);

  uart_pkg::rx_state_t state;
  uart_pkg::byte_t data_q;
  logic rx_s1;
  logic rx_s2;
  logic par_q;
  logic [2:0] bit_cnt;
  logic run;
  logic tick;

  // two-flop synchronizer for a line that idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
    end
  end

  assign run = (state != uart_pkg::rx_idle);

  // half-period preload puts every tick at mid-bit
  baud_tick u_tick (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .half  (1'b1),
    .tick  (tick)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::rx_idle;
      bit_cnt <= '0;
    end else begin
      case (state)
        uart_pkg::rx_idle: begin
          if (!rx_s2) begin
            state <= uart_pkg::rx_start;
          end
        end
        uart_pkg::rx_start: begin
          // a glitch shorter than half a bit is ignored
          if (tick) begin
            state   <= rx_s2 ? uart_pkg::rx_idle : uart_pkg::rx_data;
            bit_cnt <= '0;
          end
        end
        uart_pkg::rx_data: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::rx_parity;
            end
          end
        end
        uart_pkg::rx_parity: begin
          if (tick) begin
            state <= uart_pkg::rx_stop;
          end
        end
        uart_pkg::rx_stop: begin
          if (tick) begin
            state <= uart_pkg::rx_idle;
          end
        end
        default: state <= uart_pkg::rx_idle;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (tick && state == uart_pkg::rx_data) begin
      data_q <= {rx_s2, data_q[7:1]};
    end
    if (tick && state == uart_pkg::rx_parity) begin
      par_q <= rx_s2;
    end
  end

  assign valid = (state == uart_pkg::rx_stop) && tick;
  assign word  = {(par_q != ~^data_q), data_q};

endmodule

// File: verilog/uart_channel.sv
module uart_channel (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req,
  output logic            ack,
  input  uart_pkg::cmd_t  cmd,
  input  logic            rx,
  output logic            tx,
  output logic            full,
  output uart_pkg::read_t word,
  input  logic            take
);

  uart_pkg::cmd_t cmd_q;
  uart_pkg::byte_t tx_byte;
  uart_pkg::read_t rx_word;
  logic accept;
  logic sending;
  logic kick;
  logic lo_next;
  logic tx_start;
  logic tx_done;
  logic rx_valid;

  assign accept   = req && !ack && !sending;
  assign tx_start = kick || (lo_next && tx_done);
  assign tx_byte  = kick ? cmd_q[uart_pkg::cmd_w-1:8] : cmd_q[7:0];

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  // busy until both frames are out so ack is held off meanwhile
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack     <= 1'b0;
      sending <= 1'b0;
      kick    <= 1'b0;
      lo_next <= 1'b0;
    end else begin
      kick <= 1'b0;
      if (accept) begin
        ack     <= 1'b1;
        sending <= 1'b1;
        kick    <= 1'b1;
        lo_next <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
      if (tx_done) begin
        if (lo_next) begin
          lo_next <= 1'b0;
        end else begin
          sending <= 1'b0;
        end
      end
    end
  end

  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_byte),
    .tx    (tx),
    .busy  (),
    .done  (tx_done)
  );

  uart_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .valid (rx_valid),
    .word  (rx_word)
  );

  // one-entry buffer that drops arrivals while full
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (take) begin
      full <= 1'b0;
    end else if (rx_valid) begin
      full <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && !full) begin
      word <= rx_word;
    end
  end

  a_take_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    take |-> full
  );

endmodule

// File: verilog/cmd_dispatch.sv
module cmd_dispatch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_req,
  output logic                      cmd_ack,
  input  uart_pkg::cmd_t            cmd_data,
  input  uart_pkg::chan_t           cmd_chan,
  output logic [uart_pkg::n_chan-1:0] chan_req,
  input  logic [uart_pkg::n_chan-1:0] chan_ack,
  output uart_pkg::cmd_t            cmd
);

  uart_pkg::hs_state_t state;
  uart_pkg::chan_t chan_q;

  // single command bus held stable for the whole channel handshake
  always_ff @(posedge clk) begin
    if (state == uart_pkg::hs_idle && cmd_req) begin
      cmd    <= cmd_data;
      chan_q <= cmd_chan;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::hs_idle;
    end else begin
      case (state)
        uart_pkg::hs_idle: begin
          if (cmd_req) begin
            state <= uart_pkg::hs_wait_ack;
          end
        end
        uart_pkg::hs_wait_ack: begin
          if (chan_ack[chan_q]) begin
            state <= uart_pkg::hs_wait_release;
          end
        end
        uart_pkg::hs_wait_release: begin
          if (!chan_ack[chan_q]) begin
            state <= uart_pkg::hs_done;
          end
        end
        uart_pkg::hs_done: begin
          if (!cmd_req) begin
            state <= uart_pkg::hs_idle;
          end
        end
        default: state <= uart_pkg::hs_idle;
      endcase
    end
  end

  always_comb begin
    chan_req = '0;
    if (state == uart_pkg::hs_wait_ack) begin
      chan_req[chan_q] = 1'b1;
    end
  end

  // host sees ack only after the channel has let go
  assign cmd_ack = (state == uart_pkg::hs_done);

  // only one channel is ever inside a handshake
  a_one_chan_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(chan_req | chan_ack)
  );

endmodule

// File: verilog/read_collect.sv
module read_collect (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::n_chan-1:0] full,
  input  uart_pkg::read_t             word [uart_pkg::n_chan],
  output logic [uart_pkg::n_chan-1:0] take,
  output logic                        read_req,
  input  logic                        read_ack,
  output uart_pkg::read_t             read_data,
  output uart_pkg::chan_t             read_chan
);

  uart_pkg::hs_state_t state;
  uart_pkg::chan_t ptr;
  uart_pkg::chan_t pick;
  logic found;

  // first full buffer at or after ptr with wraparound
  always_comb begin
    uart_pkg::chan_t idx;
    found = 1'b0;
    pick  = ptr;
    for (int k = 0; k < uart_pkg::n_chan; k++) begin
      idx = uart_pkg::chan_t'(ptr + k);
      if (!found && full[idx]) begin
        found = 1'b1;
        pick  = idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == uart_pkg::hs_idle && found) begin
      read_data <= word[pick];
      read_chan <= pick;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::hs_idle;
      ptr   <= '0;
    end else begin
      case (state)
        uart_pkg::hs_idle: begin
          if (found) begin
            state <= uart_pkg::hs_wait_ack;
            ptr   <= pick + 1'b1;
          end
        end
        uart_pkg::hs_wait_ack: begin
          if (read_ack) begin
            state <= uart_pkg::hs_wait_release;
          end
        end
        uart_pkg::hs_wait_release: begin
          if (!read_ack) begin
            state <= uart_pkg::hs_idle;
          end
        end
        default: state <= uart_pkg::hs_idle;
      endcase
    end
  end

  assign read_req = (state == uart_pkg::hs_wait_ack);

  // buffer is freed as the host acks
  always_comb begin
    take = '0;
    if (state == uart_pkg::hs_wait_ack && read_ack) begin
      take[read_chan] = 1'b1;
    end
  end

  // offered buffer stays full until it is taken
  a_req_while_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_req |-> full[read_chan]
  );

endmodule

// File: verilog/uart_bridge.sv
module uart_bridge (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_req,
  output logic                        cmd_ack,
  input  uart_pkg::cmd_t              cmd_data,
  input  uart_pkg::chan_t             cmd_chan,
  input  logic [uart_pkg::n_chan-1:0] rx,
  output logic [uart_pkg::n_chan-1:0] tx,
  output logic                        read_req,
  input  logic                        read_ack,
  output uart_pkg::read_t             read_data,
  output uart_pkg::chan_t             read_chan
);

  logic [uart_pkg::n_chan-1:0] chan_req;
  logic [uart_pkg::n_chan-1:0] chan_ack;
  logic [uart_pkg::n_chan-1:0] full;
  logic [uart_pkg::n_chan-1:0] take;
  uart_pkg::cmd_t cmd_bus;
  uart_pkg::read_t ch_word [uart_pkg::n_chan];

  cmd_dispatch u_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .cmd_data (cmd_data),
    .cmd_chan (cmd_chan),
    .chan_req (chan_req),
    .chan_ack (chan_ack),
    .cmd      (cmd_bus)
  );

  for (genvar i = 0; i < uart_pkg::n_chan; i++) begin : g_chan
    uart_channel u_chan (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (chan_req[i]),
      .ack   (chan_ack[i]),
      .cmd   (cmd_bus),
      .rx    (rx[i]),
      .tx    (tx[i]),
      .full  (full[i]),
      .word  (ch_word[i]),
      .take  (take[i])
    );
  end

  read_collect u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .full      (full),
    .word      (ch_word),
    .take      (take),
    .read_req  (read_req),
    .read_ack  (read_ack),
    .read_data (read_data),
    .read_chan (read_chan)
  );

endmodule

// File: bench/tb_uart_bridge.sv
module tb_uart_bridge;

  localparam int frame_cycles = uart_pkg::frame_bits * uart_pkg::clks_per_bit;
  // 2 + 40 + 4 + 2 frames over all tests
  localparam int frame_total = 48;
  localparam int watchdog_cycles = frame_total * frame_cycles * 2 + 200 + 2000;
  localparam int cmd_limit = 4 * frame_cycles + 200;

  logic clk;
  logic rst_n;
  logic cmd_req;
  logic cmd_ack;
  uart_pkg::cmd_t cmd_data;
  uart_pkg::chan_t cmd_chan;
  logic [uart_pkg::n_chan-1:0] rx;
  logic [uart_pkg::n_chan-1:0] tx;
  logic read_req;
  logic read_ack;
  uart_pkg::read_t read_data;
  uart_pkg::chan_t read_chan;

  logic [uart_pkg::n_chan-1:0] inject_sel;
  logic [uart_pkg::n_chan-1:0] inject_line;

  uart_pkg::read_t exp_q [uart_pkg::n_chan][$];
  uart_pkg::read_t got_q [uart_pkg::n_chan][$];
  int presented [uart_pkg::n_chan];
  logic req_prev;
  int words_at_ack;
  int err_count;
  int tests_run;
  int tests_failed;

  uart_bridge uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .cmd_data  (cmd_data),
    .cmd_chan  (cmd_chan),
    .rx        (rx),
    .tx        (tx),
    .read_req  (read_req),
    .read_ack  (read_ack),
    .read_data (read_data),
    .read_chan (read_chan)
  );

  // loopback unless the injector owns the line
  assign rx = (tx & ~inject_sel) | (inject_line & inject_sel);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic odd_parity(input uart_pkg::byte_t b);
    logic p;
    p = 1'b1;
    for (int k = 0; k < 8; k++) begin
      p = p ^ b[k];
    end
    return p;
  endfunction

  // what the receiver should report for a byte sent with or without a bad parity bit
  function automatic uart_pkg::read_t expected_word(input uart_pkg::byte_t b, input bit flip);
    logic sent;
    sent = odd_parity(b) ^ flip;
    return {sent != odd_parity(b), b};
  endfunction

  // counts words offered on the read port per channel
  always @(negedge clk) begin
    if (!rst_n) begin
      req_prev <= 1'b0;
    end else begin
      if (read_req && !req_prev) begin
        presented[read_chan] <= presented[read_chan] + 1;
      end
      req_prev <= read_req;
    end
  end

  task automatic send_cmd(input uart_pkg::chan_t ch, input uart_pkg::cmd_t c);
    int n;
    exp_q[ch].push_back(expected_word(c[15:8], 1'b0));
    exp_q[ch].push_back(expected_word(c[7:0], 1'b0));
    @(negedge clk);
    cmd_data = c;
    cmd_chan = ch;
    cmd_req  = 1'b1;
    n = 0;
    while (!cmd_ack && n < cmd_limit) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ack) begin
      $display("[%0t] cmd_ack never rose for a command to channel %0d", $time, ch);
      err_count++;
    end
    words_at_ack = presented[ch];
    cmd_req = 1'b0;
    n = 0;
    while (cmd_ack && n < cmd_limit) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic inject_frame(input int ch, input uart_pkg::byte_t b, input bit flip);
    logic [uart_pkg::frame_bits-1:0] bits;
    bits = {1'b1, odd_parity(b) ^ flip, b, 1'b0};
    for (int k = 0; k < uart_pkg::frame_bits; k++) begin
      @(negedge clk);
      inject_line[ch] = bits[k];
      repeat (uart_pkg::clks_per_bit - 1) @(negedge clk);
    end
  endtask

  task automatic read_responder();
    int delay;
    forever begin
      @(negedge clk);
      if (read_req && !read_ack) begin
        delay = $urandom_range(20, 0);
        repeat (delay) @(negedge clk);
        got_q[read_chan].push_back(read_data);
        read_ack = 1'b1;
        while (read_req) @(negedge clk);
        read_ack = 1'b0;
      end
    end
  endtask

  task automatic compare_reads();
    uart_pkg::read_t got;
    uart_pkg::read_t want;
    forever begin
      @(negedge clk);
      for (int c = 0; c < uart_pkg::n_chan; c++) begin
        while (got_q[c].size() > 0) begin
          got = got_q[c].pop_front();
          if (exp_q[c].size() == 0) begin
            $display("[%0t] word %h read on channel %0d was not expected", $time, got, c);
            err_count++;
          end else begin
            want = exp_q[c].pop_front();
            assert (got == want) else begin
              $display("[ERROR] t=%0t read_data ch%0d expected %h got %h",
                       $time, c, want, got);
              err_count++;
            end
          end
        end
      end
    end
  endtask

  task automatic wait_drain(input int frames);
    int n;
    int pending;
    n = 0;
    pending = 1;
    while (pending > 0 && n < frames * frame_cycles * 2 + 500) begin
      @(negedge clk);
      n++;
      pending = 0;
      for (int c = 0; c < uart_pkg::n_chan; c++) begin
        pending += exp_q[c].size() + got_q[c].size();
      end
    end
    if (pending > 0) begin
      $display("[%0t] %0d expected words never arrived on the read port", $time, pending);
      err_count++;
      for (int c = 0; c < uart_pkg::n_chan; c++) begin
        exp_q[c].delete();
        got_q[c].delete();
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail", tests_run, name);
    end
  endtask

  initial begin
    int errs;
    int base;
    uart_pkg::cmd_t c;
    uart_pkg::byte_t b;
    void'($urandom(80783));
    rst_n       = 1'b0;
    cmd_req     = 1'b0;
    cmd_data    = '0;
    cmd_chan    = '0;
    read_ack    = 1'b0;
    inject_sel  = '0;
    inject_line = '1;
    err_count   = 0;
    tests_run   = 0;
    tests_failed = 0;
    words_at_ack = 0;
    for (int k = 0; k < uart_pkg::n_chan; k++) begin
      presented[k] = 0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      read_responder();
      compare_reads();
    join_none

    // quiet lines with no stimulus
    errs = err_count;
    repeat (200) begin
      @(negedge clk);
      assert (tx == '1) else begin
        $display("[ERROR] t=%0t tx expected %h got %h", $time, 4'hf, tx);
        err_count++;
      end
      assert (read_req == 1'b0) else begin
        $display("[ERROR] t=%0t read_req expected 0 got %b", $time, read_req);
        err_count++;
      end
    end
    report_test("idle after reset", errs);

    errs = err_count;
    send_cmd(2'd0, uart_pkg::cmd_t'($urandom));
    wait_drain(2);
    report_test("single loopback", errs);

    errs = err_count;
    for (int k = 0; k < 20; k++) begin
      c = uart_pkg::cmd_t'($urandom);
      send_cmd(uart_pkg::chan_t'($urandom_range(3, 0)), c);
    end
    wait_drain(40);
    report_test("random loopback", errs);

    // second command has to wait for both frames of the first
    errs = err_count;
    base = presented[1];
    send_cmd(2'd1, uart_pkg::cmd_t'($urandom));
    send_cmd(2'd1, uart_pkg::cmd_t'($urandom));
    assert (words_at_ack - base >= 2) else begin
      $display("[ERROR] t=%0t words_presented ch1 expected >= 2 got %0d",
               $time, words_at_ack - base);
      err_count++;
    end
    wait_drain(4);
    report_test("back-pressure", errs);

    errs = err_count;
    @(negedge clk);
    inject_sel[2] = 1'b1;
    b = uart_pkg::byte_t'($urandom);
    exp_q[2].push_back(expected_word(b, 1'b1));
    inject_frame(2, b, 1'b1);
    b = uart_pkg::byte_t'($urandom);
    exp_q[2].push_back(expected_word(b, 1'b0));
    inject_frame(2, b, 1'b0);
    wait_drain(2);
    inject_sel[2] = 1'b0;
    report_test("parity injection", errs);

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: tb.f
verilog/uart_pkg.sv
verilog/baud_tick.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_channel.sv
verilog/cmd_dispatch.sv
verilog/read_collect.sv
verilog/uart_bridge.sv
bench/tb_uart_bridge.sv
